// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int mem_words  = 1024;
  localparam int mem_addr_w = 10; // word index, above the byte offset

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_srl, alu_sra, alu_and,
    alu_or, alu_xor, alu_slt, alu_sltu, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
  } branch_e;

  typedef struct packed {
    alu_op_e alu_op;
    branch_e branch;
    logic    alu_src_imm;
    logic    a_is_pc;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    link;      // rd gets pc+4
  } ctrl_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       store_data;
    logic [xlen-1:0]       link_value;
    logic [reg_addr_w-1:0] rd;
    ctrl_t                 ctrl;
  } exec_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       wdata;
    logic                  we;
  } retire_t;

endpackage

`default_nettype wire

// ==== design/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module fetch_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    run,
  input  logic                    taken,
  input  logic [rv_pkg::xlen-1:0] target,
  output logic [rv_pkg::xlen-1:0] pc
);

  import rv_pkg::*;

  logic [xlen-1:0] next_pc;

  assign next_pc = taken ? target : pc + xlen'(4);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (run) begin
      pc <= next_pc; // holds while stopped
    end
  end

  // branch and jump targets from execute must land on word boundaries
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  );

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
  input  logic [rv_pkg::xlen-1:0] instr,
  output rv_pkg::decoded_t        dec
);

  import rv_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [xlen-1:0] imm;
  alu_op_e         alu_sel;
  ctrl_t           ctrl;
  logic            legal;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // shared by register and immediate arithmetic
  always_comb begin
    case (funct3)
      3'b000:  alu_sel = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
      3'b001:  alu_sel = alu_sll;
      3'b010:  alu_sel = alu_slt;
      3'b011:  alu_sel = alu_sltu;
      3'b100:  alu_sel = alu_xor;
      3'b101:  alu_sel = funct7[5] ? alu_sra : alu_srl;
      3'b110:  alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase
  end

  always_comb begin
    ctrl  = '0;
    imm   = '0;
    legal = 1'b1;
    case (opcode)
      opc_op: begin
        legal = (funct7 == 7'h00) ||
                (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        ctrl.alu_op    = alu_sel;
        ctrl.reg_write = 1'b1;
      end
      opc_op_imm: begin
        if (funct3 == 3'b001)
          legal = (funct7 == 7'h00);
        else if (funct3 == 3'b101)
          legal = (funct7 == 7'h00) || (funct7 == 7'h20);
        ctrl.alu_op      = alu_sel;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_i;
      end
      opc_load: begin
        legal            = (funct3 == 3'b010); // lw only
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        imm              = imm_i;
      end
      opc_store: begin
        legal            = (funct3 == 3'b010);
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
        imm              = imm_s;
      end
      opc_branch: begin
        case (funct3)
          3'b000:  ctrl.branch = br_eq;
          3'b001:  ctrl.branch = br_ne;
          3'b100:  ctrl.branch = br_lt;
          3'b101:  ctrl.branch = br_ge;
          3'b110:  ctrl.branch = br_ltu;
          3'b111:  ctrl.branch = br_geu;
          default: legal = 1'b0;
        endcase
        imm = imm_b;
      end
      opc_jal: begin
        ctrl.branch      = br_jump;
        ctrl.a_is_pc     = 1'b1; // alu forms pc + imm as the target
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.link        = 1'b1;
        imm              = imm_j;
      end
      opc_jalr: begin
        legal            = (funct3 == 3'b000);
        ctrl.branch      = br_jump;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.link        = 1'b1;
        imm              = imm_i;
      end
      opc_lui: begin
        ctrl.alu_op      = alu_pass_b;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_u;
      end
      opc_auipc: begin
        ctrl.a_is_pc     = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        imm              = imm_u;
      end
      default: legal = 1'b0;
    endcase
  end

  // unknown encodings fall out as an all-zero no-op
  always_comb begin
    dec = '0;
    if (legal) begin
      dec.ctrl = ctrl;
      dec.imm  = imm;
      if (!(opcode inside {opc_jal, opc_lui, opc_auipc}))
        dec.rs1 = instr[19:15];
      if (opcode inside {opc_op, opc_store, opc_branch})
        dec.rs2 = instr[24:20];
      if (!(opcode inside {opc_store, opc_branch}))
        dec.rd = instr[11:7];
    end
  end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`default_nettype none
`timescale 1ns/100ps

module register_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic                          we,
  input  logic [rv_pkg::xlen-1:0]       wdata,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);

  import rv_pkg::*;

  logic [2**reg_addr_w-1:0][xlen-1:0] regs;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  a_x0_hold : assert property (
    @(posedge clk) disable iff (rst) (we && rd == '0) |=> $stable(regs[0])
  );

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
  input  logic [rv_pkg::xlen-1:0] pc,
  input  rv_pkg::decoded_t        dec,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output rv_pkg::exec_t           ex,
  output logic                    taken,
  output logic [rv_pkg::xlen-1:0] target
);

  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] pc_plus4;
  logic            rs_eq, rs_lt, rs_ltu;

  assign op_a  = dec.ctrl.a_is_pc ? pc : rs1_data;
  assign op_b  = dec.ctrl.alu_src_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.ctrl.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << shamt;
      alu_srl:    alu_result = op_a >> shamt;
      alu_sra:    alu_result = $signed(op_a) >>> shamt;
      alu_and:    alu_result = op_a & op_b;
      alu_or:     alu_result = op_a | op_b;
      alu_xor:    alu_result = op_a ^ op_b;
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_pass_b: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // compares straight on the register values, not alu flags
  assign rs_eq  = (rs1_data == rs2_data);
  assign rs_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign rs_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (dec.ctrl.branch)
      br_eq:   taken = rs_eq;
      br_ne:   taken = !rs_eq;
      br_lt:   taken = rs_lt;
      br_ge:   taken = !rs_lt;
      br_ltu:  taken = rs_ltu;
      br_geu:  taken = !rs_ltu;
      br_jump: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // jumps take the alu sum, jalr drops bit 0
  assign target = (dec.ctrl.branch == br_jump) ? {alu_result[xlen-1:1], 1'b0}
                                               : pc + dec.imm;

  assign pc_plus4 = pc + xlen'(4);

  assign ex.alu_result = alu_result;
  assign ex.store_data = rs2_data;
  assign ex.link_value = pc_plus4;
  assign ex.rd         = dec.rd;
  assign ex.ctrl       = dec.ctrl;

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module memory_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    run,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [rv_pkg::xlen-1:0] paddr,
  input  logic [rv_pkg::xlen-1:0] pwdata,
  output logic [rv_pkg::xlen-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] instr,
  input  rv_pkg::exec_t           ex,
  output rv_pkg::retire_t         retire
);

  import rv_pkg::*;

  logic [xlen-1:0]       mem [mem_words];
  logic [mem_addr_w-1:0] data_idx;
  logic [mem_addr_w-1:0] apb_idx;
  logic [xlen-1:0]       load_data;
  logic                  store_we;
  logic                  apb_we;

  assign data_idx  = ex.alu_result[mem_addr_w+1:2];
  assign apb_idx   = paddr[mem_addr_w+1:2];
  assign instr     = mem[pc[mem_addr_w+1:2]];
  assign load_data = mem[data_idx];

  assign store_we = run && ex.ctrl.mem_write;
  assign apb_we   = !run && psel && penable && pwrite; // host only while stopped

  always_ff @(posedge clk) begin
    if (store_we)
      mem[data_idx] <= ex.store_data;
    else if (apb_we)
      mem[apb_idx] <= pwdata;
  end

  // read data captured in setup, presented in access
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      prdata <= '0;
    end else if (psel && !penable && !pwrite) begin
      prdata <= run ? '0 : mem[apb_idx];
    end
  end

  assign pready  = 1'b1;
  assign pslverr = psel && penable && run;

  assign retire.pc    = pc;
  assign retire.rd    = ex.rd;
  assign retire.wdata = ex.ctrl.mem_read ? load_data :
                        ex.ctrl.link     ? ex.link_value : ex.alu_result;
  assign retire.we    = run && ex.ctrl.reg_write && (ex.rd != '0);

  a_apb_setup : assert property (
    @(posedge clk) disable iff (rst) $rose(penable) |-> psel && $past(psel && !penable)
  );

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    run,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [rv_pkg::xlen-1:0] paddr,
  input  logic [rv_pkg::xlen-1:0] pwdata,
  output logic [rv_pkg::xlen-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr,
  output rv_pkg::retire_t         retire
);

  import rv_pkg::*;

  logic [xlen-1:0] pc;
  logic [xlen-1:0] instr;
  logic [xlen-1:0] target;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic            taken;
  decoded_t        dec;
  exec_t           ex;

  fetch_stage u_fetch (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .taken  (taken),
    .target (target),
    .pc     (pc)
  );

  decode_stage u_decode (
    .instr (instr),
    .dec   (dec)
  );

  register_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd       (retire.rd),
    .we       (retire.we),
    .wdata    (retire.wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_stage u_execute (
    .pc       (pc),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex       (ex),
    .taken    (taken),
    .target   (target)
  );

  memory_stage u_memory (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .pc      (pc),
    .instr   (instr),
    .ex      (ex),
    .retire  (retire)
  );

endmodule

`default_nettype wire

// ==== tests/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// architectural state of the instruction-set model
logic [31:0] m_regs [32];
logic [31:0] m_mem [1024];
logic [31:0] m_pc;

function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
  logic [31:0] res;
  case (f3)
    3'b000: res = alt ? a - b : a + b;
    3'b001: res = a << b[4:0];
    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: res = (a < b) ? 32'd1 : 32'd0;
    3'b100: res = a ^ b;
    3'b101: begin
      if (alt)
        res = $signed(a) >>> b[4:0]; // arithmetic, sign fills from the left
      else
        res = a >> b[4:0];
    end
    3'b110: res = a | b;
    default: res = a & b;
  endcase
  return res;
endfunction

// one instruction on the model state, returns what should retire
function automatic retire_t ref_step();
  logic [31:0] ins, a, b, res, nxt, addr;
  logic [31:0] imm_i, imm_s, imm_b, imm_j;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic        wr;
  logic        tk;
  retire_t     r;
  ins   = m_mem[m_pc[11:2]];
  f3    = ins[14:12];
  a     = m_regs[ins[19:15]];
  b     = m_regs[ins[24:20]];
  rd    = ins[11:7];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  res   = '0;
  wr    = 1'b0;
  tk    = 1'b0;
  nxt   = m_pc + 32'd4;
  case (ins[6:0])
    7'h33: begin
      wr  = 1'b1;
      res = expected_alu(f3, ins[30], a, b);
    end
    7'h13: begin
      wr  = 1'b1;
      res = expected_alu(f3, ins[30] && f3 == 3'b101, a, imm_i); // only srai uses bit 30
    end
    7'h03: begin
      wr   = 1'b1;
      addr = a + imm_i;
      res  = m_mem[addr[11:2]];
    end
    7'h23: begin
      addr = a + imm_s;
      m_mem[addr[11:2]] = b;
    end
    7'h63: begin
      case (f3)
        3'b000:  tk = (a == b);
        3'b001:  tk = (a != b);
        3'b100:  tk = ($signed(a) < $signed(b));
        3'b101:  tk = ($signed(a) >= $signed(b));
        3'b110:  tk = (a < b);
        default: tk = (a >= b);
      endcase
      if (tk)
        nxt = m_pc + imm_b;
    end
    7'h6f: begin
      wr  = 1'b1;
      res = m_pc + 32'd4;
      nxt = m_pc + imm_j;
    end
    7'h67: begin
      wr  = 1'b1;
      res = m_pc + 32'd4;
      nxt = (a + imm_i) & ~32'd1;
    end
    7'h37: begin
      wr  = 1'b1;
      res = {ins[31:12], 12'd0};
    end
    7'h17: begin
      wr  = 1'b1;
      res = m_pc + {ins[31:12], 12'd0};
    end
    default: wr = 1'b0;
  endcase
  if (wr && rd != 5'd0)
    m_regs[rd] = res;
  r.pc    = m_pc;
  r.rd    = rd;
  r.wdata = res;
  r.we    = wr && rd != 5'd0;
  m_pc    = nxt;
  return r;
endfunction

`endif

// ==== tests/rv_core_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core_tb;

  import rv_pkg::*;

  `include "rv_ref_model.svh"

  logic        clk;
  logic        rst;
  logic        run;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  retire_t     retire;

  logic [31:0] prog [$];
  logic [31:0] prog_end;
  retire_t     exp_ret;
  string       test_name;
  integer      seed;
  int          errors;
  int          budget;
  int          cycles;

  rv_core_top DUT (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .retire  (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // instruction encoders for the base formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1; // setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk); // no wait states
    check("pready", 32'd1, pready);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // reset, load over apb, then run until the model pc leaves the program
  task automatic run_program(input string name, input logic probe);
    logic [31:0] rdata;
    logic        err;
    int          i;
    test_name = name;
    budget += 2 * (16 + 3 * (prog.size() + 2) + prog.size() + 4);
    rst = 1'b1;
    repeat (16) @(negedge clk);
    rst  = 1'b0;
    check("reset pc", 32'd0, retire.pc);
    check("reset we", 32'd0, retire.we);
    check("reset prdata", 32'd0, prdata);
    m_pc = '0;
    for (i = 0; i < 32; i++)
      m_regs[i] = '0;
    for (i = 0; i < prog.size(); i++) begin
      apb_access(1'b1, 4 * i, prog[i], rdata, err);
      check("load pslverr", 32'd0, err);
      m_mem[i] = prog[i];
    end
    prog_end = 4 * prog.size();
    @(negedge clk);
    run = 1'b1;
    if (probe) begin
      apb_access(1'b1, 32'h40c, 32'hdeadbeef, rdata, err); // must be refused
      check("pslverr", 32'd1, err);
    end
    while (m_pc != prog_end)
      @(negedge clk);
    run = 1'b0;
  endtask

  always @(posedge clk) begin
    if (run) begin
      exp_ret = ref_step();
      check("pc", exp_ret.pc, retire.pc);
      check("we", exp_ret.we, retire.we);
      if (exp_ret.we) begin
        check("rd", exp_ret.rd, retire.rd);
        check("wdata", exp_ret.wdata, retire.wdata);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles <= budget) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the run did not finish", budget);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  task automatic alu_ops();
    logic [31:0] r;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic        alt;
    int          i;
    prog.delete();
    for (i = 1; i <= 8; i++) begin
      r = $random(seed);
      prog.push_back(i_type(r[11:0], 5'd0, 3'b000, 5'(i), 7'h13));
    end
    for (i = 0; i < 40; i++) begin
      r   = $random(seed);
      imm = $random(seed);
      f3  = r[2:0];
      alt = r[3] && (f3 == 3'b000 || f3 == 3'b101);
      if (r[19]) begin
        prog.push_back(r_type(alt ? 7'h20 : 7'h00, r[18:14], r[13:9], f3, r[8:4]));
      end else begin
        if (f3 == 3'b001 || f3 == 3'b101)
          imm[11:5] = (f3 == 3'b101 && alt) ? 7'h20 : 7'h00; // shamt form
        prog.push_back(i_type(imm[11:0], r[13:9], f3, r[8:4], 7'h13));
      end
    end
    run_program("alu_ops", 1'b0);
  endtask

  task automatic upper_imm();
    logic [31:0] r;
    logic [31:0] imm;
    int          i;
    prog.delete();
    for (i = 0; i < 12; i++) begin
      r   = $random(seed);
      imm = $random(seed);
      prog.push_back(u_type(imm[19:0], r[4:0], r[5] ? 7'h37 : 7'h17));
    end
    run_program("upper_imm", 1'b0);
  endtask

  task automatic load_store();
    logic [31:0] r;
    logic [31:0] rdata;
    logic        err;
    int          i;
    prog.delete();
    prog.push_back(i_type(12'd1056, 5'd0, 3'b000, 5'd10, 7'h13)); // base 0x420
    for (i = 0; i < 8; i++) begin
      r = $random(seed);
      prog.push_back(u_type(r[31:12], 5'(11 + i), 7'h37));
      prog.push_back(i_type(r[11:0], 5'(11 + i), 3'b000, 5'(11 + i), 7'h13));
    end
    for (i = 0; i < 8; i++)
      prog.push_back(s_type(12'(4 * i - 32), 5'(11 + i), 5'd10));
    for (i = 0; i < 8; i++)
      prog.push_back(i_type(12'(4 * (7 - i) - 32), 5'd10, 3'b010, 5'(20 + i), 7'h03));
    run_program("load_store", 1'b0);
    budget += 2 * 3 * 8;
    for (i = 0; i < 8; i++) begin
      apb_access(1'b0, 32'h400 + 4 * i, 32'd0, rdata, err);
      check("readback", m_mem[256 + i], rdata);
    end
  endtask

  task automatic branches();
    logic [2:0] kinds [6];
    logic [4:0] lhs [4];
    logic [4:0] rhs [4];
    int         k;
    int         p;
    kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    lhs   = '{5'd1, 5'd1, 5'd2, 5'd4}; // equal, signed less, reversed, both less
    rhs   = '{5'd3, 5'd2, 5'd1, 5'd1};
    prog.delete();
    prog.push_back(i_type(12'hffb, 5'd0, 3'b000, 5'd1, 7'h13));
    prog.push_back(i_type(12'd3, 5'd0, 3'b000, 5'd2, 7'h13));
    prog.push_back(i_type(12'hffb, 5'd0, 3'b000, 5'd3, 7'h13));
    prog.push_back(i_type(12'hff9, 5'd0, 3'b000, 5'd4, 7'h13));
    for (k = 0; k < 6; k++) begin
      for (p = 0; p < 4; p++) begin
        prog.push_back(b_type(13'd8, rhs[p], lhs[p], kinds[k]));
        prog.push_back(i_type(12'd1, 5'd20, 3'b000, 5'd20, 7'h13)); // skipped when taken
      end
    end
    run_program("branches", 1'b0);
  endtask

  task automatic jumps();
    logic [31:0] skip;
    skip = i_type(12'd1, 5'd9, 3'b000, 5'd9, 7'h13);
    prog.delete();
    prog.push_back(j_type(21'd8, 5'd5));
    prog.push_back(skip);
    prog.push_back(u_type(20'd0, 5'd6, 7'h17));
    prog.push_back(i_type(12'd17, 5'd6, 3'b000, 5'd6, 7'h13)); // odd target
    prog.push_back(i_type(12'd0, 5'd6, 3'b000, 5'd7, 7'h67));
    prog.push_back(skip);
    prog.push_back(j_type(21'd8, 5'd0));
    prog.push_back(skip);
    prog.push_back(i_type(12'd16, 5'd6, 3'b000, 5'd11, 7'h67));
    prog.push_back(skip);
    prog.push_back(r_type(7'h00, 5'd11, 5'd5, 3'b000, 5'd12));
    run_program("jumps", 1'b0);
  endtask

  task automatic zero_reg();
    logic [31:0] rdata;
    logic        err;
    prog.delete();
    prog.push_back(i_type(12'd77, 5'd0, 3'b000, 5'd1, 7'h13));
    prog.push_back(i_type(12'd55, 5'd0, 3'b000, 5'd0, 7'h13));
    prog.push_back(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
    prog.push_back(u_type(20'h12345, 5'd0, 7'h37));
    prog.push_back(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd2));
    prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd3, 7'h13));
    prog.push_back(r_type(7'h20, 5'd1, 5'd0, 3'b000, 5'd4));
    prog.push_back(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd5));
    run_program("zero_reg", 1'b1);
    apb_access(1'b0, 32'h40c, 32'd0, rdata, err);
    check("readback", m_mem[259], rdata);
  endtask

  initial begin
    rst     = 1'b1;
    run     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    seed    = 32'h85f11894;
    errors  = 0;
    budget  = 0;
    alu_ops();
    upper_imm();
    load_store();
    branches();
    jumps();
    zero_reg();
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+tests
design/rv_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_core_top.sv
tests/rv_core_tb.sv
